//--- tb.f
+incdir+.
floo_pkg.sv
floo_sa_global_arbiter.sv
floo_vc_credit_tracker.sv
floo_vc_assignment.sv
floo_output_link.sv
floo_vc_output_port.sv
tb_floo_vc_output_port.sv

//--- tb_floo_vc_output_port.sv
`include "floo_vc_macros.svh"

module tb_floo_vc_output_port;

  import floo_pkg::*;

  localparam int NumInputs     = `FLOO_NUM_INPUTS;
  localparam int NumVC         = `FLOO_NUM_VC;
  localparam int NumRows       = 15;
  localparam int WaitLimit     = 16;
  localparam int TimeoutCycles = NumRows * 20;

  // one table row: request, optional credit return, responder timing, expected result
  typedef struct {
    logic [NumInputs-1:0] valid;
    route_direction_e     route;
    logic                 require_vc;
    logic                 credit_v;
    vc_id_t               credit_vc;
    int                   ack_delay;
    int                   ack_hold;
    logic                 exp_grant;
    int                   exp_winner;
    int                   exp_vc;
  } row_t;

  logic                                      clk_i;
  logic                                      rst_i;
  logic             [NumInputs-1:0]          in_valid_i;
  route_direction_e [NumInputs-1:0]          in_route_i;
  logic             [NumInputs-1:0]          in_require_vc_i;
  flit_t            [NumInputs-1:0]          in_flit_i;
  input_oh_t                                 in_grant_o;
  logic                                      credit_v_i;
  vc_id_t                                    credit_vc_i;
  logic                                      link_req_o;
  logic                                      link_ack_i;
  vc_id_t                                    link_vc_o;
  route_direction_e                          link_route_o;
  flit_t                                     link_flit_o;

  row_t        stim [NumRows];
  int          model_cred [NumVC];
  int          model_last;
  logic [15:0] lfsr_state;
  int          ack_delay;
  int          ack_hold;
  int          errors;
  int          checks;
  int          row_errors;

  floo_vc_output_port i_floo_vc_output_port (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .in_valid_i      (in_valid_i),
    .in_route_i      (in_route_i),
    .in_require_vc_i (in_require_vc_i),
    .in_flit_i       (in_flit_i),
    .in_grant_o      (in_grant_o),
    .credit_v_i      (credit_v_i),
    .credit_vc_i     (credit_vc_i),
    .link_req_o      (link_req_o),
    .link_ack_i      (link_ack_i),
    .link_vc_o       (link_vc_o),
    .link_route_o    (link_route_o),
    .link_flit_o     (link_flit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // taps 16, 14, 13, 11
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic flit_t random_flit();
    flit_t f;
    for (int b = 0; b < `FLOO_FLIT_WIDTH; b++) begin
      f[b] = lfsr_step();
    end
    return f;
  endfunction

  // next requester after the last winner, -1 if nobody asks
  function automatic int rr_pick(input logic [NumInputs-1:0] mask);
    int idx;
    idx = model_last;
    for (int n = 0; n < NumInputs; n++) begin
      idx = (idx == NumInputs - 1) ? 0 : idx + 1;
      if (mask[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  // own VC first, lowest VC with credit otherwise, -1 when nothing fits
  function automatic int pick_vc(input route_direction_e route, input logic require_vc);
    int slot;
    case (route)
      North:   slot = 0;
      East:    slot = 1;
      South:   slot = 2;
      default: slot = 3;
    endcase
    if (model_cred[slot] > 0) begin
      return slot;
    end
    if (require_vc) begin
      return -1;
    end
    for (int v = 0; v < NumVC; v++) begin
      if (model_cred[v] > 0) begin
        return v;
      end
    end
    return -1;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      row_errors++;
    end
  endtask

  // downstream router side of the four-phase link
  initial begin
    int   cnt;
    int   delay;
    int   hold;
    logic busy;
    link_ack_i = 1'b0;
    cnt        = 0;
    delay      = 0;
    hold       = 0;
    busy       = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      if (link_req_o && !link_ack_i) begin
        // timing is taken from the row whose flit is on the link
        if (!busy) begin
          busy  = 1'b1;
          delay = ack_delay;
          hold  = ack_hold;
          cnt   = 0;
        end
        if (cnt >= delay) begin
          link_ack_i = 1'b1;
          cnt        = 0;
        end else begin
          cnt++;
        end
      end else if (link_ack_i) begin
        assert (!link_req_o) else begin
          $display("link_req_o rose again while ack was still held high");
          errors++;
        end
        if (cnt >= hold) begin
          link_ack_i = 1'b0;
          busy       = 1'b0;
        end else begin
          cnt++;
        end
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout, the run did not complete within %0d cycles", TimeoutCycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int        model_win;
    int        model_vc;
    int        waited;
    logic      exp_go;
    input_oh_t got;
    input_oh_t last_grant;
    flit_t     exp_flit;

    // valid, route, require, credit_v, credit_vc, delay, hold, grant, winner, vc
    stim[0]  = '{5'b00001, North, 1'b0, 1'b0, 2'd0, 0, 0, 1'b1, 0, 0};
    stim[1]  = '{5'b10000, East,  1'b0, 1'b0, 2'd0, 0, 0, 1'b1, 4, 1};
    stim[2]  = '{5'b00100, South, 1'b0, 1'b0, 2'd0, 0, 0, 1'b1, 2, 2};
    stim[3]  = '{5'b00010, Eject, 1'b0, 1'b0, 2'd0, 0, 0, 1'b1, 1, 3};
    stim[4]  = '{5'b00010, Eject, 1'b0, 1'b0, 2'd0, 1, 0, 1'b1, 1, 3};
    stim[5]  = '{5'b01000, Eject, 1'b0, 1'b0, 2'd0, 0, 0, 1'b1, 3, 0};
    stim[6]  = '{5'b00001, Eject, 1'b1, 1'b0, 2'd0, 0, 0, 1'b0, 0, 0};
    stim[7]  = '{5'b00001, Eject, 1'b1, 1'b1, 2'd3, 0, 0, 1'b1, 0, 3};
    stim[8]  = '{5'b10001, East,  1'b0, 1'b1, 2'd0, 0, 0, 1'b1, 4, 1};
    stim[9]  = '{5'b10001, East,  1'b0, 1'b1, 2'd1, 0, 1, 1'b1, 0, 1};
    stim[10] = '{5'b10001, East,  1'b0, 1'b0, 2'd0, 0, 0, 1'b1, 4, 0};
    stim[11] = '{5'b10001, East,  1'b0, 1'b1, 2'd1, 0, 0, 1'b1, 0, 1};
    stim[12] = '{5'b00100, South, 1'b0, 1'b0, 2'd0, 2, 6, 1'b1, 2, 2};
    stim[13] = '{5'b00010, Eject, 1'b1, 1'b1, 2'd3, 0, 0, 1'b1, 1, 3};
    stim[14] = '{5'b01000, North, 1'b0, 1'b1, 2'd2, 0, 0, 1'b1, 3, 2};

    errors          = 0;
    checks          = 0;
    lfsr_state      = 16'd2;
    ack_delay       = 0;
    ack_hold        = 0;
    model_last      = NumInputs - 1;
    last_grant      = '0;
    rst_i           = 1'b1;
    in_valid_i      = '0;
    in_require_vc_i = '0;
    in_flit_i       = '0;
    credit_v_i      = 1'b0;
    credit_vc_i     = '0;
    for (int i = 0; i < NumInputs; i++) begin
      in_route_i[i] = North;
    end
    for (int v = 0; v < NumVC; v++) begin
      model_cred[v] = `FLOO_CREDIT_DEPTH;
    end

    repeat (3) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    row_errors = 0;
    @(negedge clk_i);
    compare_value("link_req_o", link_req_o, 0);
    compare_value("in_grant_o", in_grant_o, 0);
    $display("reset state %s", (row_errors == 0) ? "ok" : "wrong");
    @(posedge clk_i);
    #2;

    for (int r = 0; r < NumRows; r++) begin
      row_errors = 0;
      ack_delay  = stim[r].ack_delay;
      ack_hold   = stim[r].ack_hold;
      // a returned credit gets a cycle of its own before the request
      if (stim[r].credit_v) begin
        in_valid_i  = in_valid_i & ~last_grant;
        credit_v_i  = 1'b1;
        credit_vc_i = stim[r].credit_vc;
        model_cred[stim[r].credit_vc]++;
        @(posedge clk_i);
        #2;
        credit_v_i = 1'b0;
      end
      in_valid_i      = stim[r].valid;
      in_require_vc_i = {NumInputs{stim[r].require_vc}};
      for (int i = 0; i < NumInputs; i++) begin
        in_route_i[i] = stim[r].route;
        in_flit_i[i]  = stim[r].valid[i] ? random_flit() : '0;
      end

      model_win = rr_pick(stim[r].valid);
      model_vc  = pick_vc(stim[r].route, stim[r].require_vc);
      exp_go    = (model_win >= 0) && (model_vc >= 0);
      assert (exp_go == stim[r].exp_grant && (!exp_go
              || (model_win == stim[r].exp_winner && model_vc == stim[r].exp_vc))) else begin
        $display("row %0d of the table disagrees with the reference model", r);
        errors++;
        row_errors++;
      end

      got    = '0;
      waited = 0;
      while (got == '0 && waited < WaitLimit) begin
        @(negedge clk_i);
        waited++;
        got = in_grant_o;
        assert (!(got != '0 && link_ack_i)) else begin
          $display("grant was given while the link ack was still high");
          errors++;
          row_errors++;
        end
      end

      if (exp_go) begin
        compare_value("in_grant_o", got, 1 << model_win);
        if (got != '0) begin
          exp_flit = in_flit_i[model_win];
          model_cred[model_vc]--;
          model_last = model_win;
          last_grant = got;
          // the flit shows up on the link one cycle after the transfer
          @(negedge clk_i);
          compare_value("link_req_o", link_req_o, 1);
          compare_value("link_vc_o", link_vc_o, model_vc);
          compare_value("link_route_o", link_route_o, stim[r].route);
          compare_value("link_flit_o", link_flit_o, exp_flit);
        end
      end else begin
        compare_value("in_grant_o", got, 0);
        last_grant = '0;
      end
      @(posedge clk_i);
      #2;
      $display("row %0d winner %0d vc %0d %s", r, model_win, model_vc,
               (row_errors == 0) ? "ok" : "failed");
    end

    in_valid_i = '0;
    $display("%0d rows, %0d checks, %0d errors", NumRows, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- floo_vc_output_port.sv
`include "floo_vc_macros.svh"

// east output port allocation: switch arbiter, VC credits,
// VC assignment and the link to the next router
module floo_vc_output_port (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  input  logic                       [`FLOO_NUM_INPUTS-1:0]   in_valid_i,
  input  floo_pkg::route_direction_e [`FLOO_NUM_INPUTS-1:0]   in_route_i,
  input  logic                       [`FLOO_NUM_INPUTS-1:0]   in_require_vc_i,
  input  floo_pkg::flit_t            [`FLOO_NUM_INPUTS-1:0]   in_flit_i,
  output floo_pkg::input_oh_t                                 in_grant_o,
  input  logic                                                credit_v_i,
  input  floo_pkg::vc_id_t                                    credit_vc_i,
  output logic                                                link_req_o,
  input  logic                                                link_ack_i,
  output floo_pkg::vc_id_t                                    link_vc_o,
  output floo_pkg::route_direction_e                          link_route_o,
  output floo_pkg::flit_t                                     link_flit_o
);

  import floo_pkg::*;

  localparam int NumInputs = `FLOO_NUM_INPUTS;

  logic                          sa_global_v;
  input_oh_t                     sa_global_oh;
  logic   [`FLOO_NUM_VC-1:0]     vc_selection_v;
  vc_id_t [`FLOO_NUM_VC-1:0]     vc_selection_id;
  logic                          vc_assignment_v;
  vc_id_t                        vc_assignment_id;
  route_direction_e              look_ahead_sel;
  logic                          link_free;
  logic                          transfer;

  // running OR for the one-hot flit select
  flit_t flit_or [NumInputs+1];
  flit_t flit_sel;

  // a flit leaves only with a VC in hand and an idle link
  assign transfer   = vc_assignment_v & link_free;
  assign in_grant_o = sa_global_oh & {NumInputs{transfer}};

  assign flit_or[0] = '0;
  for (genvar i = 0; i < NumInputs; i++) begin : gen_flit_sel
    assign flit_or[i+1] = flit_or[i] | (in_flit_i[i] & {`FLOO_FLIT_WIDTH{sa_global_oh[i]}});
  end
  assign flit_sel = flit_or[NumInputs];

  floo_sa_global_arbiter i_floo_sa_global_arbiter (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (in_valid_i),
    .advance_i  (transfer),
    .valid_o    (sa_global_v),
    .grant_oh_o (sa_global_oh)
  );

  floo_vc_credit_tracker i_floo_vc_credit_tracker (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .consume_i         (transfer),
    .consume_vc_i      (vc_assignment_id),
    .credit_v_i        (credit_v_i),
    .credit_vc_i       (credit_vc_i),
    .vc_selection_v_o  (vc_selection_v),
    .vc_selection_id_o (vc_selection_id)
  );

  floo_vc_assignment i_floo_vc_assignment (
    .sa_global_v_i            (sa_global_v),
    .sa_global_input_dir_oh_i (sa_global_oh),
    .look_ahead_routing_i     (in_route_i),
    .require_correct_vc_i     (in_require_vc_i),
    .vc_selection_v_i         (vc_selection_v),
    .vc_selection_id_i        (vc_selection_id),
    .vc_assignment_v_o        (vc_assignment_v),
    .vc_assignment_id_o       (vc_assignment_id),
    .look_ahead_routing_sel_o (look_ahead_sel)
  );

  floo_output_link i_floo_output_link (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .load_i       (transfer),
    .load_vc_i    (vc_assignment_id),
    .load_route_i (look_ahead_sel),
    .load_flit_i  (flit_sel),
    .link_free_o  (link_free),
    .link_req_o   (link_req_o),
    .link_ack_i   (link_ack_i),
    .link_vc_o    (link_vc_o),
    .link_route_o (link_route_o),
    .link_flit_o  (link_flit_o)
  );

endmodule

//--- floo_output_link.sv
`include "floo_vc_macros.svh"

// output register and four-phase req/ack link to the next router
module floo_output_link (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       load_i,
  input  floo_pkg::vc_id_t           load_vc_i,
  input  floo_pkg::route_direction_e load_route_i,
  input  floo_pkg::flit_t            load_flit_i,
  output logic                       link_free_o,
  output logic                       link_req_o,
  input  logic                       link_ack_i,
  output floo_pkg::vc_id_t           link_vc_o,
  output floo_pkg::route_direction_e link_route_o,
  output floo_pkg::flit_t            link_flit_o
);

  import floo_pkg::*;

  link_state_e state_q;
  link_state_e state_d;

  vc_id_t           vc_q;
  route_direction_e route_q;
  flit_t            flit_q;

  // req up, wait for ack, req down, wait for ack to drop
  always_comb begin
    state_d = state_q;
    case (state_q)
      LinkIdle: begin
        if (load_i) begin
          state_d = LinkReq;
        end
      end
      LinkReq: begin
        if (link_ack_i) begin
          state_d = LinkWaitLow;
        end
      end
      LinkWaitLow: begin
        if (!link_ack_i) begin
          state_d = LinkIdle;
        end
      end
      default: begin
        state_d = LinkIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LinkIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // capture happens on the transfer edge only
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      vc_q    <= load_vc_i;
      route_q <= load_route_i;
      flit_q  <= load_flit_i;
    end
  end

  assign link_free_o  = (state_q == LinkIdle);
  assign link_req_o   = (state_q == LinkReq);
  assign link_vc_o    = vc_q;
  assign link_route_o = route_q;
  assign link_flit_o  = flit_q;

  // the receiver samples any time during req, so nothing may move under it
  assert property (@(posedge clk_i) disable iff (rst_i)
    link_req_o |=> !link_req_o
                   || ($stable(link_vc_o) && $stable(link_route_o) && $stable(link_flit_o)))
    else $error("link payload changed while req was high");

endmodule

//--- floo_vc_assignment.sv
`include "floo_vc_macros.svh"

// VC assignment after the global switch arbiter
// takes the candidate VC that the tracker prepared for the winner's next hop
module floo_vc_assignment (
  input  logic                                                  sa_global_v_i,
  input  floo_pkg::input_oh_t                                   sa_global_input_dir_oh_i,
  input  floo_pkg::route_direction_e [`FLOO_NUM_INPUTS-1:0]     look_ahead_routing_i,
  input  logic                       [`FLOO_NUM_INPUTS-1:0]     require_correct_vc_i,
  input  logic                       [`FLOO_NUM_VC-1:0]         vc_selection_v_i,
  input  floo_pkg::vc_id_t           [`FLOO_NUM_VC-1:0]         vc_selection_id_i,
  output logic                                                  vc_assignment_v_o,
  output floo_pkg::vc_id_t                                      vc_assignment_id_o,
  output floo_pkg::route_direction_e                            look_ahead_routing_sel_o
);

  import floo_pkg::*;

  localparam int NumInputs  = `FLOO_NUM_INPUTS;
  localparam int RouteWidth = $bits(route_direction_e);

  logic [RouteWidth-1:0] route_sel_raw;
  logic                  require_sel;

  // candidate slot for the selected next hop
  vc_id_t slot;
  logic   slot_ok;

  // one-hot mux, the grant picks route and flag of the winning input
  always_comb begin
    route_sel_raw = '0;
    require_sel   = 1'b0;
    for (int i = 0; i < NumInputs; i++) begin
      route_sel_raw = route_sel_raw
                    | (look_ahead_routing_i[i] & {RouteWidth{sa_global_input_dir_oh_i[i]}});
      require_sel   = require_sel
                    | (require_correct_vc_i[i] & sa_global_input_dir_oh_i[i]);
    end
  end

  assign look_ahead_routing_sel_o = route_direction_e'(route_sel_raw);

  // the tracker orders its candidates by the VC each next hop prefers
  // on the east output under XY the downstream router forwards
  // north, east, south or ejects, a turn back west cannot happen
  always_comb begin
    slot    = '0;
    slot_ok = 1'b1;
    case (look_ahead_routing_sel_o)
      North: begin
        slot = vc_id_t'(0);
      end
      East: begin
        slot = vc_id_t'(1);
      end
      South: begin
        slot = vc_id_t'(2);
      end
      Eject: begin
        slot = vc_id_t'(3);
      end
      default: begin
        slot_ok = 1'b0;
      end
    endcase
  end

  assign vc_assignment_id_o = vc_selection_id_i[slot];

  // a flit that insists on its own VC waits until exactly that VC is free
  assign vc_assignment_v_o = sa_global_v_i
                           & slot_ok
                           & vc_selection_v_i[slot]
                           & (~require_sel | (vc_assignment_id_o == slot));

  // route computation upstream must never send a westbound hop through east
  always_comb begin
    assert final (!(sa_global_v_i && (look_ahead_routing_sel_o == West)))
      else $error("look-ahead route West selected at the east output");
  end

endmodule

//--- floo_vc_credit_tracker.sv
`include "floo_vc_macros.svh"

// credit bookkeeping for the downstream VCs of one output port
// and the VC candidate for every next-hop slot
module floo_vc_credit_tracker (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    consume_i,
  input  floo_pkg::vc_id_t                        consume_vc_i,
  input  logic                                    credit_v_i,
  input  floo_pkg::vc_id_t                        credit_vc_i,
  output logic             [`FLOO_NUM_VC-1:0]     vc_selection_v_o,
  output floo_pkg::vc_id_t [`FLOO_NUM_VC-1:0]     vc_selection_id_o
);

  import floo_pkg::*;

  localparam int          NumVC     = `FLOO_NUM_VC;
  localparam credit_cnt_t CreditMax = credit_cnt_t'(`FLOO_CREDIT_DEPTH);

  credit_cnt_t [NumVC-1:0] credit_cnt_q;
  logic        [NumVC-1:0] credit_inc;
  logic        [NumVC-1:0] credit_dec;
  logic        [NumVC-1:0] has_credit;

  // lowest VC that still has room downstream
  logic   lowest_free_v;
  vc_id_t lowest_free_id;

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      credit_inc[v] = credit_v_i && (credit_vc_i == vc_id_t'(v));
      credit_dec[v] = consume_i && (consume_vc_i == vc_id_t'(v));
      has_credit[v] = (credit_cnt_q[v] != '0);
    end
  end

  // a return and a send on the same VC in one cycle leave the count alone
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int v = 0; v < NumVC; v++) begin
        credit_cnt_q[v] <= CreditMax;
      end
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        if (credit_inc[v] && !credit_dec[v]) begin
          credit_cnt_q[v] <= credit_cnt_q[v] + 1'b1;
        end else if (credit_dec[v] && !credit_inc[v]) begin
          credit_cnt_q[v] <= credit_cnt_q[v] - 1'b1;
        end
      end
    end
  end

  // scan from the top so the lowest free VC wins
  always_comb begin
    lowest_free_v  = 1'b0;
    lowest_free_id = '0;
    for (int v = NumVC - 1; v >= 0; v--) begin
      if (has_credit[v]) begin
        lowest_free_v  = 1'b1;
        lowest_free_id = vc_id_t'(v);
      end
    end
  end

  // slot k prefers VC k, otherwise falls back to the lowest free one
  always_comb begin
    for (int k = 0; k < NumVC; k++) begin
      if (has_credit[k]) begin
        vc_selection_v_o[k]  = 1'b1;
        vc_selection_id_o[k] = vc_id_t'(k);
      end else begin
        vc_selection_v_o[k]  = lowest_free_v;
        vc_selection_id_o[k] = lowest_free_id;
      end
    end
  end

  // a flit is only sent on a VC the downstream buffer can take
  assert property (@(posedge clk_i) disable iff (rst_i)
    consume_i |-> credit_cnt_q[consume_vc_i] != '0)
    else $error("flit sent on VC %0d with no credit left", consume_vc_i);

  // downstream never returns more credits than it has slots
  assert property (@(posedge clk_i) disable iff (rst_i)
    credit_v_i |-> credit_cnt_q[credit_vc_i] != CreditMax)
    else $error("credit returned to VC %0d which is already full", credit_vc_i);

endmodule

//--- floo_sa_global_arbiter.sv
`include "floo_vc_macros.svh"

// global stage of switch allocation for one output port
// rotating priority, the input after the last winner goes first
module floo_sa_global_arbiter (
  input  logic                clk_i,
  input  logic                rst_i,
  input  floo_pkg::input_oh_t req_i,
  input  logic                advance_i,
  output logic                valid_o,
  output floo_pkg::input_oh_t grant_oh_o
);

  localparam int NumInputs = `FLOO_NUM_INPUTS;
  localparam int PtrWidth  = $clog2(NumInputs);

  // index of the input that took the last transfer
  logic [PtrWidth-1:0] last_winner_q;
  logic [PtrWidth-1:0] winner_idx;

  always_comb begin
    int idx;
    valid_o    = 1'b0;
    grant_oh_o = '0;
    winner_idx = last_winner_q;
    idx        = 0;
    // walk once around the ring, starting right after the last winner
    for (int off = 1; off <= NumInputs; off++) begin
      idx = (int'(last_winner_q) + off) % NumInputs;
      if (!valid_o && req_i[idx]) begin
        valid_o         = 1'b1;
        grant_oh_o[idx] = 1'b1;
        winner_idx      = PtrWidth'(idx);
      end
    end
  end

  // pointer moves only when the granted flit actually leaves,
  // so a blocked winner keeps its turn
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // last winner is the top input, which puts input 0 first
      last_winner_q <= PtrWidth'(NumInputs - 1);
    end else if (advance_i) begin
      last_winner_q <= winner_idx;
    end
  end

  // exactly one input is granted, and it is one that asked
  assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o |-> $onehot(grant_oh_o) && ((grant_oh_o & req_i) == grant_oh_o))
    else $error("global arbiter grant is not one-hot over the requests");

  // advancing without a winner would hand the turn to nobody
  assert property (@(posedge clk_i) disable iff (rst_i)
    advance_i |-> valid_o)
    else $error("arbiter advanced without a valid grant");

endmodule

//--- floo_pkg.sv
`include "floo_vc_macros.svh"

package floo_pkg;

  // next-hop direction as seen by the router after this one
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_direction_e;

  // index of a downstream virtual channel
  typedef logic [$clog2(`FLOO_NUM_VC)-1:0] vc_id_t;

  // one bit per input port, used for masks and one-hot grants
  typedef logic [`FLOO_NUM_INPUTS-1:0] input_oh_t;

  typedef logic [`FLOO_FLIT_WIDTH-1:0] flit_t;

  // must hold 0 up to the full buffer depth
  typedef logic [$clog2(`FLOO_CREDIT_DEPTH+1)-1:0] credit_cnt_t;

  // four-phase req/ack link towards the next router
  typedef enum logic [1:0] {
    LinkIdle,
    LinkReq,
    LinkWaitLow
  } link_state_e;

endpackage

//--- floo_vc_macros.svh
`ifndef FLOO_VC_MACROS_SVH
`define FLOO_VC_MACROS_SVH

// sizes of the east output port allocation slice

// virtual channels on the link towards the next router
`define FLOO_NUM_VC 4

// input ports competing for this output (N, E, S, W, local)
`define FLOO_NUM_INPUTS 5

// payload bits carried by one head flit
`define FLOO_FLIT_WIDTH 16

// buffer slots per downstream VC, also the credit count after reset
`define FLOO_CREDIT_DEPTH 2

`endif
